// File: Makefile
# Verilator build and run of the memory subsystem testbench
# Override any variable on the command line, for example make run LOG=run2.log

VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
PASS_MSG  ?= Finished with no errors

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The log decides the result, the simulator exit code is not trusted
run: compile
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: access_counters.sv
// Saturating counters of completed reads, writes and decode errors
// One count event per finished transaction

`timescale 1ns/10ps

module access_counters (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mem_map_pkg::count_evt_t count_evt_i,
    output mem_map_pkg::perf_t      perf_o
);

    import mem_map_pkg::*;

    perf_t perf_q;

    // Stick at all ones instead of wrapping
    function automatic logic [CNT_W-1:0] sat_inc(input logic [CNT_W-1:0] v);
        return (v == '1) ? v : v + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst_n) begin
            perf_q <= '0;
        end else if (count_evt_i.valid) begin
            if (count_evt_i.err)
                perf_q.errors <= sat_inc(perf_q.errors);    // Either kind
            else if (count_evt_i.kind == ACC_WRITE)
                perf_q.writes <= sat_inc(perf_q.writes);
            else
                perf_q.reads  <= sat_inc(perf_q.reads);
        end
    end

    assign perf_o = perf_q;

endmodule

// File: axil_pkg.sv
// AXI4-Lite channel widths and vector types
// Response code enum
// Master-to-slave and slave-to-master channel structs

package axil_pkg;

    // ========================================
    // Widths
    // ========================================
    localparam int AXIL_ADDR_W = 32;                 // Byte address
    localparam int AXIL_DATA_W = 32;                 // One word per beat
    localparam int AXIL_STRB_W = AXIL_DATA_W / 8;    // One strobe per byte lane

    typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [AXIL_DATA_W-1:0] axil_data_t;
    typedef logic [AXIL_STRB_W-1:0] axil_strb_t;

    // BRESP / RRESP codes, EXOKAY and DECERR are never returned
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_e;

    // ========================================
    // Channel bundles
    // ========================================

    // Driven by the master
    typedef struct packed {
        logic       awvalid;
        axil_addr_t awaddr;
        logic       wvalid;
        axil_data_t wdata;
        axil_strb_t wstrb;
        logic       bready;
        logic       arvalid;
        axil_addr_t araddr;
        logic       rready;
    } axil_req_t;

    // Driven by the slave
    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        axil_resp_e bresp;
        logic       arready;
        logic       rvalid;
        axil_data_t rdata;
        axil_resp_e rresp;
    } axil_rsp_t;

endpackage

// File: axil_txn_fsm.sv
// AXI4-Lite slave state machine
// Accepts one read or write, issues one memory request,
// holds the B or R response until the master takes it
// and reports each completed access to the counters

`timescale 1ns/10ps

module axil_txn_fsm (
    input  logic                    clk,
    input  logic                    rst_n,
    input  axil_pkg::axil_req_t     axil_req_i,
    output axil_pkg::axil_rsp_t     axil_rsp_o,
    output mem_map_pkg::mem_req_t   mem_req_o,
    input  mem_map_pkg::mem_rsp_t   mem_rsp_i,
    output mem_map_pkg::count_evt_t count_evt_o
);

    import axil_pkg::*;
    import mem_map_pkg::*;

    typedef enum logic [2:0] {
        IDLE,      // Waiting for AR or AW+W
        ISSUE,     // Memory request on the bus
        WAIT,      // Router answering
        B_RESP,    // Write response held
        R_RESP     // Read response held
    } state_e;

    state_e state_q;

    // Control flops
    logic req_valid_q;
    logic bvalid_q;
    logic rvalid_q;
    logic evt_valid_q;

    // Captured transaction and response payload
    access_kind_e kind_q;
    axil_addr_t   addr_q;
    axil_data_t   wdata_q;
    axil_strb_t   wstrb_q;
    axil_data_t   rdata_q;
    axil_resp_e   resp_q;    // Shared by B and R, only one is ever open

    logic rd_acc;      // AR handshake this cycle
    logic wr_acc;      // AW and W handshake together this cycle
    logic rsp_take;    // Router response captured this cycle

    // ========================================
    // Acceptance
    // ========================================

    // A pending read wins over a pending write
    assign rd_acc = (state_q == IDLE) && axil_req_i.arvalid;
    assign wr_acc = (state_q == IDLE) && !axil_req_i.arvalid
                    && axil_req_i.awvalid && axil_req_i.wvalid;

    assign rsp_take = (state_q == WAIT) && mem_rsp_i.valid;

    // ========================================
    // State and control
    // ========================================
    always_ff @(posedge clk) begin
        if (rst_n) begin
            state_q     <= IDLE;
            req_valid_q <= 1'b0;
            bvalid_q    <= 1'b0;
            rvalid_q    <= 1'b0;
            evt_valid_q <= 1'b0;
        end else begin
            req_valid_q <= 1'b0;    // Strobes last one cycle
            evt_valid_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (rd_acc || wr_acc) begin
                        req_valid_q <= 1'b1;
                        state_q     <= ISSUE;
                    end
                end
                ISSUE: state_q <= WAIT;    // Router samples the request here
                WAIT: begin
                    if (rsp_take) begin
                        evt_valid_q <= 1'b1;    // Count on capture, not on handshake
                        if (kind_q == ACC_WRITE) begin
                            bvalid_q <= 1'b1;
                            state_q  <= B_RESP;
                        end else begin
                            rvalid_q <= 1'b1;
                            state_q  <= R_RESP;
                        end
                    end
                end
                B_RESP: begin
                    if (axil_req_i.bready) begin
                        bvalid_q <= 1'b0;
                        state_q  <= IDLE;
                    end
                end
                R_RESP: begin
                    if (axil_req_i.rready) begin
                        rvalid_q <= 1'b0;
                        state_q  <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Payload capture
    always_ff @(posedge clk) begin
        if (rd_acc) begin
            kind_q  <= ACC_READ;
            addr_q  <= axil_req_i.araddr;
            wdata_q <= '0;
            wstrb_q <= '0;
        end else if (wr_acc) begin
            kind_q  <= ACC_WRITE;
            addr_q  <= axil_req_i.awaddr;
            wdata_q <= axil_req_i.wdata;
            wstrb_q <= axil_req_i.wstrb;
        end
        if (rsp_take) begin
            resp_q <= mem_rsp_i.err ? RESP_SLVERR : RESP_OKAY;
            if (kind_q == ACC_READ)
                rdata_q <= mem_rsp_i.rdata;    // Already zero on decode error
        end
    end

    // ========================================
    // Outputs
    // ========================================
    always_comb begin
        axil_rsp_o.awready = wr_acc;    // AW and W ready in the same cycle
        axil_rsp_o.wready  = wr_acc;
        axil_rsp_o.arready = rd_acc;
        axil_rsp_o.bvalid  = bvalid_q;
        axil_rsp_o.bresp   = resp_q;
        axil_rsp_o.rvalid  = rvalid_q;
        axil_rsp_o.rdata   = rdata_q;
        axil_rsp_o.rresp   = resp_q;
    end

    always_comb begin
        mem_req_o.valid = req_valid_q;
        mem_req_o.kind  = kind_q;
        mem_req_o.addr  = addr_q;
        mem_req_o.wdata = wdata_q;
        mem_req_o.wstrb = wstrb_q;
    end

    always_comb begin
        count_evt_o.valid = evt_valid_q;
        count_evt_o.kind  = kind_q;
        count_evt_o.err   = (resp_q == RESP_SLVERR);
    end

endmodule

// File: list.f
axil_pkg.sv
mem_map_pkg.sv
region_ram.sv
region_router.sv
access_counters.sv
axil_txn_fsm.sv
mem_subsys_top.sv
tb_mem_subsys.sv

// File: mem_map_pkg.sv
// Memory-map widths for the region memories
// Access kind enum
// Memory request / response structs, per-region RAM request
// Access counter and count event structs

package mem_map_pkg;

    import axil_pkg::*;

    localparam int RAM_IDX_W = 16;    // Word index width toward a region RAM
    localparam int CNT_W     = 16;    // Width of each access counter

    // Kind of memory access
    typedef enum logic {
        ACC_READ  = 1'b0,
        ACC_WRITE = 1'b1
    } access_kind_e;

    // ========================================
    // Request path
    // ========================================

    // One access from the AXI slave FSM to the router
    typedef struct packed {
        logic         valid;    // Single-cycle strobe
        access_kind_e kind;
        axil_addr_t   addr;     // Byte address, low two bits ignored
        axil_data_t   wdata;
        axil_strb_t   wstrb;
    } mem_req_t;

    // Router answer, one cycle after the request
    typedef struct packed {
        logic       valid;
        logic       err;      // Address hit no region
        axil_data_t rdata;    // Zero on error
    } mem_rsp_t;

    // Request to a single region RAM
    typedef struct packed {
        logic                 en;
        logic                 we;
        logic [RAM_IDX_W-1:0] widx;    // Word index relative to the region base
        axil_data_t           wdata;
        axil_strb_t           wstrb;
    } ram_req_t;

    // ========================================
    // Counters
    // ========================================
    typedef struct packed {
        logic [CNT_W-1:0] reads;     // OKAY reads
        logic [CNT_W-1:0] writes;    // OKAY writes
        logic [CNT_W-1:0] errors;    // Decode errors of either kind
    } perf_t;

    // One completed access
    typedef struct packed {
        logic         valid;
        access_kind_e kind;
        logic         err;
    } count_evt_t;

endpackage

// File: mem_subsys_top.sv
// Memory subsystem top level
// AXI4-Lite slave FSM, region router, two region RAMs and access counters
// Memory map set here and passed down

`timescale 1ns/10ps

module mem_subsys_top #(
    parameter axil_pkg::axil_addr_t REGION0_BASE = 32'h0000_0000,
    parameter int                   REGION0_AW   = 10,    // 1K words
    parameter axil_pkg::axil_addr_t REGION1_BASE = 32'h0000_1000,
    parameter int                   REGION1_AW   = 12     // 4K words
) (
    input  logic                clk,
    input  logic                rst_n,
    input  axil_pkg::axil_req_t axil_req_i,
    output axil_pkg::axil_rsp_t axil_rsp_o,
    output mem_map_pkg::perf_t  perf_o
);

    import axil_pkg::*;
    import mem_map_pkg::*;

    mem_req_t   mem_req;
    mem_rsp_t   mem_rsp;
    ram_req_t   ram0_req;
    ram_req_t   ram1_req;
    axil_data_t ram0_rdata;
    axil_data_t ram1_rdata;
    count_evt_t count_evt;

    // ========================================
    // Bus side
    // ========================================
    axil_txn_fsm i_axil_txn_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .axil_req_i  (axil_req_i),
        .axil_rsp_o  (axil_rsp_o),
        .mem_req_o   (mem_req),
        .mem_rsp_i   (mem_rsp),
        .count_evt_o (count_evt)
    );

    // ========================================
    // Memory side
    // ========================================
    region_router #(
        .REGION0_BASE (REGION0_BASE),
        .REGION0_AW   (REGION0_AW),
        .REGION1_BASE (REGION1_BASE),
        .REGION1_AW   (REGION1_AW)
    ) i_region_router (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_req_i    (mem_req),
        .mem_rsp_o    (mem_rsp),
        .ram0_req_o   (ram0_req),
        .ram1_req_o   (ram1_req),
        .ram0_rdata_i (ram0_rdata),
        .ram1_rdata_i (ram1_rdata)
    );

    region_ram #(.ADDR_W(REGION0_AW)) i_region0_ram (
        .clk       (clk),
        .ram_req_i (ram0_req),
        .rdata_o   (ram0_rdata)
    );

    region_ram #(.ADDR_W(REGION1_AW)) i_region1_ram (
        .clk       (clk),
        .ram_req_i (ram1_req),
        .rdata_o   (ram1_rdata)
    );

    access_counters i_access_counters (
        .clk         (clk),
        .rst_n       (rst_n),
        .count_evt_i (count_evt),
        .perf_o      (perf_o)
    );

endmodule

// File: region_ram.sv
// Single-port word RAM for one region
// Per-byte write enables from the strobe, registered read

`timescale 1ns/10ps

module region_ram #(
    parameter int ADDR_W = 10    // 2^ADDR_W words
) (
    input  logic                  clk,
    input  mem_map_pkg::ram_req_t ram_req_i,
    output axil_pkg::axil_data_t  rdata_o
);

    import axil_pkg::*;

    axil_data_t        mem_q [2**ADDR_W];
    axil_data_t        rdata_q;
    logic [ADDR_W-1:0] idx;

    // Router index is wider than this region needs
    assign idx = ram_req_i.widx[ADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (ram_req_i.en) begin
            if (ram_req_i.we) begin
                for (int b = 0; b < AXIL_STRB_W; b++) begin
                    if (ram_req_i.wstrb[b])
                        mem_q[idx][8*b +: 8] <= ram_req_i.wdata[8*b +: 8];
                end
            end else begin
                rdata_q <= mem_q[idx];    // Valid the cycle after the request
            end
        end
    end

    assign rdata_o = rdata_q;

endmodule

// File: region_router.sv
// Region address decoder
// Steers a memory request to region 0 or region 1 RAM,
// flags a decode error for the hole, and muxes read data back

`timescale 1ns/10ps

module region_router #(
    parameter axil_pkg::axil_addr_t REGION0_BASE = 32'h0000_0000,
    parameter int                   REGION0_AW   = 10,
    parameter axil_pkg::axil_addr_t REGION1_BASE = 32'h0000_1000,
    parameter int                   REGION1_AW   = 12
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mem_map_pkg::mem_req_t mem_req_i,
    output mem_map_pkg::mem_rsp_t mem_rsp_o,
    output mem_map_pkg::ram_req_t ram0_req_o,
    output mem_map_pkg::ram_req_t ram1_req_o,
    input  axil_pkg::axil_data_t  ram0_rdata_i,
    input  axil_pkg::axil_data_t  ram1_rdata_i
);

    import axil_pkg::*;
    import mem_map_pkg::*;

    // Region ends, one bit wider so a top-of-map region cannot wrap
    localparam logic [AXIL_ADDR_W:0] WORD_BYTES  = 4;
    localparam logic [AXIL_ADDR_W:0] REGION0_END = {1'b0, REGION0_BASE}
                                                   + (WORD_BYTES << REGION0_AW);
    localparam logic [AXIL_ADDR_W:0] REGION1_END = {1'b0, REGION1_BASE}
                                                   + (WORD_BYTES << REGION1_AW);

    axil_addr_t word_addr;    // Byte address with the low two bits cleared
    axil_addr_t off0;
    axil_addr_t off1;
    logic       hit0;
    logic       hit1;

    logic valid_q;    // Response due this cycle
    logic sel1_q;     // Region 1 answered
    logic err_q;      // No region answered

    // ========================================
    // Decode
    // ========================================
    always_comb begin
        word_addr = {mem_req_i.addr[AXIL_ADDR_W-1:2], 2'b00};
        off0      = word_addr - REGION0_BASE;
        off1      = word_addr - REGION1_BASE;
        // Region 0 checked first
        hit0 = (word_addr >= REGION0_BASE) && ({1'b0, word_addr} < REGION0_END);
        hit1 = !hit0 && (word_addr >= REGION1_BASE)
               && ({1'b0, word_addr} < REGION1_END);
    end

    // RAM requests, enable only on a hit so the hole writes nothing
    always_comb begin
        ram0_req_o.en    = mem_req_i.valid && hit0;
        ram0_req_o.we    = (mem_req_i.kind == ACC_WRITE);
        ram0_req_o.widx  = off0[RAM_IDX_W+1:2];
        ram0_req_o.wdata = mem_req_i.wdata;
        ram0_req_o.wstrb = mem_req_i.wstrb;

        ram1_req_o.en    = mem_req_i.valid && hit1;
        ram1_req_o.we    = (mem_req_i.kind == ACC_WRITE);
        ram1_req_o.widx  = off1[RAM_IDX_W+1:2];
        ram1_req_o.wdata = mem_req_i.wdata;
        ram1_req_o.wstrb = mem_req_i.wstrb;
    end

    // ========================================
    // Response stage
    // ========================================
    always_ff @(posedge clk) begin
        if (rst_n)
            valid_q <= 1'b0;
        else
            valid_q <= mem_req_i.valid;
    end

    always_ff @(posedge clk) begin
        if (mem_req_i.valid) begin
            sel1_q <= hit1;
            err_q  <= !(hit0 || hit1);
        end
    end

    // RAM read word lands in the same cycle as valid_q
    always_comb begin
        mem_rsp_o.valid = valid_q;
        mem_rsp_o.err   = err_q;
        if (err_q)
            mem_rsp_o.rdata = '0;
        else if (sel1_q)
            mem_rsp_o.rdata = ram1_rdata_i;
        else
            mem_rsp_o.rdata = ram0_rdata_i;
    end

endmodule

// File: tb_mem_subsys.sv
// Self-checking testbench for the memory subsystem
// LCG-driven AXI4-Lite reads and writes with random back-pressure
// Reference word memory with known-bit masks and expected counters
// Compare tasks for data, response codes and counters

`timescale 1ns/10ps

module tb_mem_subsys;

    import axil_pkg::*;
    import mem_map_pkg::*;

    localparam axil_addr_t REGION0_BASE = 32'h0000_0000;
    localparam int         REGION0_AW   = 10;    // 1K words
    localparam axil_addr_t REGION1_BASE = 32'h0000_1000;
    localparam int         REGION1_AW   = 12;    // 4K words
    localparam int         NUM_TXN      = 400;   // Random transactions
    localparam int         NUM_DIRECTED = 28;    // Boundary and race transactions
    localparam int         MAX_CYCLES   = 12 * (NUM_TXN + NUM_DIRECTED) + 100;

    // Last of region 0, first and last of region 1, first of the hole
    localparam axil_addr_t EDGE_ADDR [4] = '{32'h0FFC, 32'h1000, 32'h4FFC, 32'h5000};

    logic      clk = 1'b0;
    logic      rst_n;
    axil_req_t req;
    axil_rsp_t rsp;
    perf_t     perf;

    logic [31:0] lcg_state = 32'd80;
    int          cycle_cnt = 0;

    axil_data_t model_mem   [int unsigned];    // Keyed by word address
    axil_data_t model_known [int unsigned];    // Bits written at least once
    perf_t      exp_perf;

    mem_subsys_top #(
        .REGION0_BASE (REGION0_BASE),
        .REGION0_AW   (REGION0_AW),
        .REGION1_BASE (REGION1_BASE),
        .REGION1_AW   (REGION1_AW)
    ) i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .axil_req_i (req),
        .axil_rsp_o (rsp),
        .perf_o     (perf)
    );

    always #4 clk = ~clk;    // 8 ns period

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > MAX_CYCLES)
            stop_run($sformatf("Timeout: run still busy after %0d cycles", cycle_cnt));
    end

    // ========================================
    // Helpers
    // ========================================
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1);
    endtask

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];    // Upper bits have the longer period
    endfunction

    function automatic axil_data_t rand_word();
        axil_data_t w;
        w[31:16] = lcg_next();
        w[15:0]  = lcg_next();
        return w;
    endfunction

    function automatic logic ready_draw();
        logic [15:0] r;
        r = lcg_next();
        return r[3:2] != 2'b00;    // Ready in 3 of 4 cycles
    endfunction

    // Byte address inside 8 blocks of 1K words and near either end of a block
    function automatic axil_addr_t pick_addr();
        logic [15:0] r;
        logic [9:0]  off;
        r   = lcg_next();
        off = r[5] ? {7'h7F, r[8:6]} : {7'h00, r[8:6]};
        return {17'h0, r[2:0], off, r[10:9]};    // Low two bits must not matter
    endfunction

    function automatic axil_data_t strb_mask(input axil_strb_t s);
        axil_data_t m;
        for (int b = 0; b < AXIL_STRB_W; b++)
            m[8*b +: 8] = {8{s[b]}};
        return m;
    endfunction

    // 0 for region 0, 1 for region 1, 2 for the hole
    function automatic int region_of(input axil_addr_t addr);
        logic [AXIL_ADDR_W:0] a;
        a = {1'b0, addr[AXIL_ADDR_W-1:2], 2'b00};
        if (a >= {1'b0, REGION0_BASE} && a < {1'b0, REGION0_BASE} + (33'd4 << REGION0_AW))
            return 0;
        if (a >= {1'b0, REGION1_BASE} && a < {1'b0, REGION1_BASE} + (33'd4 << REGION1_AW))
            return 1;
        return 2;
    endfunction

    // ========================================
    // Compare tasks
    // ========================================
    task automatic check_data(input string name, input axil_data_t got, input axil_data_t exp);
        if (got !== exp)
            stop_run($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp));
    endtask

    task automatic check_resp(input string name, input axil_resp_e got, input axil_resp_e exp);
        if (got !== exp)
            stop_run($sformatf("[FAIL] %s: got 0x%01h, expected 0x%01h", name, got, exp));
    endtask

    task automatic check_perf(input string name, input perf_t got, input perf_t exp);
        if (got !== exp)
            stop_run($sformatf("[FAIL] %s: got 0x%012h, expected 0x%012h", name, got, exp));
    endtask

    // ========================================
    // Bus side
    // ========================================
    task automatic wait_accept(input logic is_read);
        @(negedge clk);
        while (is_read ? !rsp.arready : !(rsp.awready && rsp.wready))
            @(negedge clk);
    endtask

    // Random ready each cycle
    // Valid must rise 2 cycles after acceptance and then hold
    task automatic take_resp(input logic is_read, output axil_data_t data,
                             output axil_resp_e resp);
        int         n;
        logic       ready;
        logic       valid;
        axil_resp_e now_resp;
        string      rname;
        n     = 0;
        data  = '0;
        resp  = RESP_OKAY;
        rname = is_read ? "rresp" : "bresp";
        forever begin
            @(posedge clk);
            ready = ready_draw();
            if (is_read)
                req.rready <= ready;
            else
                req.bready <= ready;
            @(negedge clk);
            n++;
            valid    = is_read ? rsp.rvalid : rsp.bvalid;
            now_resp = is_read ? rsp.rresp : rsp.bresp;
            if (valid != (n >= 2))
                stop_run($sformatf("Response valid was %0b %0d cycles after acceptance",
                                   valid, n));
            if (n == 2) begin
                resp = now_resp;
                if (is_read)
                    data = rsp.rdata;
            end else if (n > 2) begin
                check_resp(rname, now_resp, resp);    // Held under back-pressure
                if (is_read)
                    check_data("rdata", rsp.rdata, data);
            end
            if (valid && ready)
                break;
        end
        @(posedge clk);    // Handshake edge
        req.rready <= 1'b0;
        req.bready <= 1'b0;
    endtask

    // ========================================
    // Model
    // ========================================
    task automatic expect_write(input axil_addr_t addr, input axil_data_t data,
                                input axil_strb_t strb, input axil_resp_e resp);
        int unsigned key;
        axil_data_t  m;
        key = addr >> 2;
        if (region_of(addr) == 2) begin
            check_resp("bresp", resp, RESP_SLVERR);    // Model left untouched
            exp_perf.errors = exp_perf.errors + 1'b1;
        end else begin
            check_resp("bresp", resp, RESP_OKAY);
            m = strb_mask(strb);
            if (!model_mem.exists(key)) begin
                model_mem[key]   = '0;
                model_known[key] = '0;
            end
            model_mem[key]   = (model_mem[key] & ~m) | (data & m);
            model_known[key] = model_known[key] | m;
            exp_perf.writes  = exp_perf.writes + 1'b1;
        end
    endtask

    task automatic expect_read(input axil_addr_t addr, input axil_data_t data,
                               input axil_resp_e resp);
        int unsigned key;
        key = addr >> 2;
        if (region_of(addr) == 2) begin
            check_resp("rresp", resp, RESP_SLVERR);
            check_data("rdata", data, '0);
            exp_perf.errors = exp_perf.errors + 1'b1;
        end else begin
            check_resp("rresp", resp, RESP_OKAY);
            if (model_mem.exists(key))    // Only bits ever written are known
                check_data("rdata", data & model_known[key], model_mem[key] & model_known[key]);
            exp_perf.reads = exp_perf.reads + 1'b1;
        end
    endtask

    // ========================================
    // Transactions
    // ========================================
    task automatic do_write(input axil_addr_t addr, input axil_data_t data,
                            input axil_strb_t strb);
        axil_data_t dummy;
        axil_resp_e resp;
        @(posedge clk);
        req.awvalid <= 1'b1;
        req.awaddr  <= addr;
        req.wvalid  <= 1'b1;
        req.wdata   <= data;
        req.wstrb   <= strb;
        wait_accept(1'b0);
        @(posedge clk);
        req.awvalid <= 1'b0;
        req.wvalid  <= 1'b0;
        take_resp(1'b0, dummy, resp);
        expect_write(addr, data, strb, resp);
    endtask

    task automatic do_read(input axil_addr_t addr);
        axil_data_t data;
        axil_resp_e resp;
        @(posedge clk);
        req.arvalid <= 1'b1;
        req.araddr  <= addr;
        wait_accept(1'b1);
        @(posedge clk);
        req.arvalid <= 1'b0;
        take_resp(1'b1, data, resp);
        expect_read(addr, data, resp);
    endtask

    // AR, AW and W raised together where the read must win and see the old word
    task automatic do_race(input axil_addr_t addr, input axil_data_t data,
                           input axil_strb_t strb);
        axil_data_t rdata;
        axil_resp_e resp;
        @(posedge clk);
        req.arvalid <= 1'b1;
        req.araddr  <= addr;
        req.awvalid <= 1'b1;
        req.awaddr  <= addr;
        req.wvalid  <= 1'b1;
        req.wdata   <= data;
        req.wstrb   <= strb;
        wait_accept(1'b1);
        if (rsp.awready || rsp.wready)
            stop_run("Write was accepted in the same cycle as a pending read");
        @(posedge clk);
        req.arvalid <= 1'b0;
        take_resp(1'b1, rdata, resp);
        expect_read(addr, rdata, resp);
        wait_accept(1'b0);    // Write still pending
        @(posedge clk);
        req.awvalid <= 1'b0;
        req.wvalid  <= 1'b0;
        take_resp(1'b0, rdata, resp);
        expect_write(addr, data, strb, resp);
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        logic [15:0] r;
        axil_addr_t  addr;
        rst_n    <= 1'b1;
        req      <= '0;
        exp_perf = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b0;
        @(negedge clk);
        check_perf("perf_o", perf, '0);

        // Full word then a partial merge at each region edge
        for (int i = 0; i < 4; i++) begin
            addr = EDGE_ADDR[i];
            do_write(addr, {addr[15:0], ~addr[15:0]}, 4'hF);
            do_read(addr);
            do_write(addr, rand_word(), 4'b0101);
            do_read(addr);
        end

        // A misrouted edge write shows up here as an alias of another edge
        for (int i = 0; i < 4; i++)
            do_read(EDGE_ADDR[i]);

        // Simultaneous read and write to the same word in each region
        do_write(32'h0000_0010, 32'hA5A5_5A5A, 4'hF);
        do_race(32'h0000_0010, 32'h1234_5678, 4'b0011);
        do_read(32'h0000_0010);
        do_write(32'h0000_2004, 32'h0F0F_F0F0, 4'hF);
        do_race(32'h0000_2004, 32'hCAFE_F00D, 4'b1100);
        do_read(32'h0000_2004);

        // Random mix over both regions and the hole
        for (int i = 0; i < NUM_TXN; i++) begin
            r    = lcg_next();
            addr = pick_addr();
            if (r[0])
                do_write(addr, rand_word(), r[7:4]);
            else
                do_read(addr);
        end

        @(posedge clk);
        @(negedge clk);
        check_perf("perf_o", perf, exp_perf);
        $display("Finished with no errors");
        $finish;
    end

endmodule
